// File: lc3b_defines.svh
// lc3b core sizing
// word width, register count and register index width shared by the
// decode and execute front

`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// data and address word
`define LC3B_WORD_W 16

// general purpose register file
`define LC3B_NUM_REGS 8
`define LC3B_REG_IDX_W 3

`endif

// File: lc3b_types.sv
// lc3b ISA types
// data word, register index and the opcode and ALU operation encodings

`include "lc3b_defines.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [`LC3B_REG_IDX_W-1:0] lc3b_reg;

    // standard LC-3b opcode field, instr[15:12]
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_passa,
        alu_passb
    } lc3b_aluop;

endpackage : lc3b_types

// File: lc3b_ctrl_pkg.sv
// lc3b pipeline records
// control word from the decoder and the structs carried between stages

package lc3b_ctrl_pkg;

    import lc3b_types::*;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        // address adder selects
        logic       addr1mux_sel;
        logic [1:0] addr2mux_sel;
        logic       addr3mux_sel;
        logic       lshf;
        // control transfer
        logic       br_op;
        logic       jsr_op;
        logic       trap_op;
        logic       jmp_op;
        logic       uncond_op;
        // operand and write-back selects
        logic       sr2mux_sel;
        logic       storemux_sel;
        logic [1:0] wbmux_sel;
        logic       dest_mux_sel;
        logic       load_reg;
        logic       load_cc;
        // data memory request
        logic       dcacheR;
        logic       dcacheW;
        logic       dcache_enable;
        logic       d_mem_byte_sel;
        logic       alu_result_mux_sel;
        logic       stb_op;
        logic       ldi_op;
        logic       ldb_op;
        lc3b_word   pc;
    } lc3b_control_word;

    // decode to execute record
    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_word         ir;
        lc3b_word         sr1_val;
        lc3b_word         sr2_val;
        lc3b_reg          dest;
    } idex_t;

    // cc is {n, z, p}
    typedef struct packed {
        logic       reg_we;
        lc3b_reg    dest;
        lc3b_word   value;
        logic [2:0] cc;
        logic       mem_rd;
        logic       mem_wr;
        logic       mem_byte;
        lc3b_word   mem_addr;
        lc3b_word   mem_wdata;
        logic       redirect;
        lc3b_word   target;
    } retire_t;

endpackage : lc3b_ctrl_pkg

// File: control_rom.sv
// lc3b control ROM
// combinational decode of the opcode into the pipeline control word,
// unknown opcodes give an all-zero word

module control_rom
(
    input  lc3b_types::lc3b_opcode        opcode,
    input  logic                          ir11,
    input  logic                          ir5,
    input  lc3b_types::lc3b_word          pc,
    output lc3b_ctrl_pkg::lc3b_control_word ctrl
);

    import lc3b_types::*;

    always_comb
    begin
        // defaults, every field gets one
        ctrl.opcode = opcode;
        ctrl.aluop = alu_passa;
        ctrl.addr1mux_sel = 1'b0;
        ctrl.addr2mux_sel = 2'b00;
        ctrl.addr3mux_sel = 1'b0;
        ctrl.lshf = 1'b0;
        ctrl.br_op = 1'b0;
        ctrl.jsr_op = 1'b0;
        ctrl.trap_op = 1'b0;
        ctrl.jmp_op = 1'b0;
        ctrl.uncond_op = 1'b0;
        ctrl.sr2mux_sel = 1'b0;
        ctrl.storemux_sel = 1'b0;
        ctrl.wbmux_sel = 2'b00;
        ctrl.dest_mux_sel = 1'b0;
        ctrl.load_reg = 1'b0;
        ctrl.load_cc = 1'b0;
        ctrl.dcacheR = 1'b0;
        ctrl.dcacheW = 1'b0;
        ctrl.dcache_enable = 1'b0;
        ctrl.d_mem_byte_sel = 1'b0;
        ctrl.alu_result_mux_sel = 1'b0;
        ctrl.stb_op = 1'b0;
        ctrl.ldi_op = 1'b0;
        ctrl.ldb_op = 1'b0;
        ctrl.pc = pc;

        case (opcode)
            op_add, op_and, op_not:
            begin
                ctrl.aluop = (opcode == op_add) ? alu_add :
                             (opcode == op_and) ? alu_and : alu_not;
                ctrl.load_reg = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.wbmux_sel = 2'b11;
                // imm5 form, not has no second operand
                ctrl.sr2mux_sel = ir5 && (opcode != op_not);
            end

            op_shf:
            begin
                ctrl.alu_result_mux_sel = 1'b1;
                ctrl.load_reg = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.wbmux_sel = 2'b11;
            end

            op_ldr, op_ldb, op_ldi:
            begin
                ctrl.addr1mux_sel = 1'b1;
                ctrl.addr2mux_sel = 2'b01;
                // byte loads use the unscaled offset
                ctrl.lshf = (opcode != op_ldb);
                ctrl.wbmux_sel = 2'b01;
                ctrl.load_reg = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.dcacheR = 1'b1;
                ctrl.dcache_enable = 1'b1;
                ctrl.d_mem_byte_sel = (opcode == op_ldb);
                ctrl.ldb_op = (opcode == op_ldb);
                ctrl.ldi_op = (opcode == op_ldi);
            end

            op_str, op_stb, op_sti:
            begin
                ctrl.addr1mux_sel = 1'b1;
                ctrl.addr2mux_sel = 2'b01;
                ctrl.lshf = (opcode != op_stb);
                ctrl.storemux_sel = 1'b1;
                ctrl.aluop = alu_passb;
                ctrl.dcacheW = 1'b1;
                ctrl.dcache_enable = 1'b1;
                ctrl.d_mem_byte_sel = (opcode == op_stb);
                ctrl.stb_op = (opcode == op_stb);
            end

            op_br:
            begin
                ctrl.addr2mux_sel = 2'b10;
                ctrl.lshf = 1'b1;
                ctrl.br_op = 1'b1;
            end

            op_lea:
            begin
                ctrl.addr2mux_sel = 2'b10;
                ctrl.lshf = 1'b1;
                ctrl.load_reg = 1'b1;
                ctrl.load_cc = 1'b1;
            end

            // jmp and ret, target is sr1 + 0
            op_jmp:
            begin
                ctrl.addr1mux_sel = 1'b1;
                ctrl.jmp_op = 1'b1;
                ctrl.uncond_op = 1'b1;
            end

            op_jsr:
            begin
                ctrl.jsr_op = 1'b1;
                ctrl.uncond_op = 1'b1;
                ctrl.dest_mux_sel = 1'b1;
                ctrl.load_reg = 1'b1;
                ctrl.wbmux_sel = 2'b10;
                if (ir11)
                begin
                    ctrl.addr2mux_sel = 2'b11;
                    ctrl.lshf = 1'b1;
                end
                else
                begin
                    // jsrr jumps through the base register
                    ctrl.addr1mux_sel = 1'b1;
                    ctrl.jmp_op = 1'b1;
                end
            end

            op_trap:
            begin
                ctrl.trap_op = 1'b1;
                ctrl.addr3mux_sel = 1'b1;
                ctrl.dest_mux_sel = 1'b1;
                ctrl.load_reg = 1'b1;
                ctrl.wbmux_sel = 2'b10;
                ctrl.dcacheR = 1'b1;
                ctrl.dcache_enable = 1'b1;
            end

            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule : control_rom

// File: regfile.sv
// lc3b register file
// eight general purpose registers, two read ports and one write port,
// a read of the register being written returns the new data

`include "lc3b_defines.svh"

module regfile
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  lc3b_types::lc3b_reg  sr1,
    input  lc3b_types::lc3b_reg  sr2,
    output lc3b_types::lc3b_word sr1_out,
    output lc3b_types::lc3b_word sr2_out,
    input  logic                 we,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word wdata
);

    import lc3b_types::*;

    lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            regs[dest] <= wdata;
        end
    end

    // execute writes while the next instruction decodes
    assign sr1_out = (we && (dest == sr1)) ? wdata : regs[sr1];
    assign sr2_out = (we && (dest == sr2)) ? wdata : regs[sr2];

endmodule : regfile

// File: stage_reg.sv
// pipeline stage register
// valid bit plus a payload of any packed type, payload loads only
// with a valid input so a bubble keeps the old data

module stage_reg #(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            out_data <= '0;
        end
        else
        begin
            out_valid <= in_valid;
            if (in_valid)
                out_data <= in_data;
        end
    end

endmodule : stage_reg

// File: lc3b_alu.sv
// lc3b ALU
// add, and, not and the two pass operations, or the SHF result on a

module lc3b_alu
(
    input  lc3b_types::lc3b_aluop aluop,
    input  lc3b_types::lc3b_word  a,
    input  lc3b_types::lc3b_word  b,
    input  logic                  shf_en,
    input  logic [1:0]            shf_ctl,
    input  logic [3:0]            shf_amt,
    output lc3b_types::lc3b_word  f
);

    import lc3b_types::*;

    always_comb
    begin
        if (shf_en)
        begin
            // shf_ctl is {A, D} from ir[5:4]
            if (!shf_ctl[0])
                f = a << shf_amt;
            else if (shf_ctl[1])
                f = lc3b_word'($signed(a) >>> shf_amt);
            else
                f = a >> shf_amt;
        end
        else
        begin
            case (aluop)
                alu_add:   f = a + b;
                alu_and:   f = a & b;
                alu_not:   f = ~a;
                alu_passb: f = b;
                default:   f = a;
            endcase
        end
    end

endmodule : lc3b_alu

// File: exec_stage.sv
// lc3b execute stage
// ALU, address adder, condition codes, branch resolution and the
// register write-back, builds the next retire record

module exec_stage
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid,
    input  lc3b_ctrl_pkg::idex_t   idex,
    output logic                   rf_we,
    output lc3b_types::lc3b_reg    rf_dest,
    output lc3b_types::lc3b_word   rf_wdata,
    output lc3b_ctrl_pkg::retire_t retire_next
);

    import lc3b_types::*;
    import lc3b_ctrl_pkg::*;

    lc3b_control_word ctrl;
    lc3b_word         ir;
    lc3b_word         pc_plus2;
    lc3b_word         alu_b;
    lc3b_word         alu_f;
    lc3b_word         base1;
    lc3b_word         offset;
    lc3b_word         addr;
    logic [2:0]       cc_q;
    logic [2:0]       cc_new;
    logic             wb_ok;
    logic             cc_load;
    logic             br_match;

    assign ctrl = idex.ctrl;
    assign ir = idex.ir;
    assign pc_plus2 = ctrl.pc + lc3b_word'(2);
    assign alu_b = ctrl.sr2mux_sel ? {{11{ir[4]}}, ir[4:0]} : idex.sr2_val;

    lc3b_alu alu_i (
        .aluop   (ctrl.aluop),
        .a       (idex.sr1_val),
        .b       (alu_b),
        .shf_en  (ctrl.alu_result_mux_sel),
        .shf_ctl (ir[5:4]),
        .shf_amt (ir[3:0]),
        .f       (alu_f)
    );

    // address adder
    assign base1 = ctrl.addr1mux_sel ? idex.sr1_val : pc_plus2;

    always_comb
    begin
        case (ctrl.addr2mux_sel)
            2'b01:   offset = {{10{ir[5]}}, ir[5:0]};
            2'b10:   offset = {{7{ir[8]}}, ir[8:0]};
            2'b11:   offset = {{5{ir[10]}}, ir[10:0]};
            default: offset = '0;
        endcase
        if (ctrl.lshf)
            offset = offset << 1;
    end

    assign addr = ctrl.addr3mux_sel ? {7'b0, ir[7:0], 1'b0} : base1 + offset;

    // loads and trap finish in the memory stage
    assign wb_ok = valid && !ctrl.dcacheR;
    assign rf_we = wb_ok && ctrl.load_reg;
    assign rf_dest = idex.dest;

    always_comb
    begin
        case (ctrl.wbmux_sel)
            2'b11:   rf_wdata = alu_f;
            2'b10:   rf_wdata = pc_plus2;
            default: rf_wdata = addr;
        endcase
    end

    assign cc_load = wb_ok && ctrl.load_cc;
    assign cc_new = {rf_wdata[15], rf_wdata == '0, !rf_wdata[15] && (rf_wdata != '0)};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cc_q <= 3'b010;
        else if (cc_load)
            cc_q <= cc_new;
    end

    // nzp of the branch against the current codes
    assign br_match = |(ir[11:9] & cc_q);

    always_comb
    begin
        retire_next.reg_we = rf_we;
        retire_next.dest = rf_dest;
        retire_next.value = rf_wdata;
        retire_next.cc = cc_load ? cc_new : cc_q;
        retire_next.mem_rd = valid && ctrl.dcache_enable && ctrl.dcacheR;
        retire_next.mem_wr = valid && ctrl.dcache_enable && ctrl.dcacheW;
        retire_next.mem_byte = valid && ctrl.dcache_enable && ctrl.d_mem_byte_sel;
        retire_next.mem_addr = addr;
        // a byte store drives its byte on both lanes
        retire_next.mem_wdata = ctrl.stb_op ? {alu_f[7:0], alu_f[7:0]} : alu_f;
        retire_next.redirect = valid && (ctrl.uncond_op || (ctrl.br_op && br_match));
        retire_next.target = addr;
    end

endmodule : exec_stage

// File: lc3b_decode_exec.sv
// lc3b decode and execute front
// decoder, register file, decode/execute and retire stage registers
// around the execute stage, two cycles from instruction to retire

module lc3b_decode_exec
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  lc3b_types::lc3b_word   instr,
    input  lc3b_types::lc3b_word   pc,
    output lc3b_ctrl_pkg::retire_t retire,
    output logic                   retire_valid
);

    import lc3b_types::*;
    import lc3b_ctrl_pkg::*;

    lc3b_control_word ctrl;
    lc3b_reg          sr2_idx;
    lc3b_reg          dest;
    lc3b_word         sr1_out;
    lc3b_word         sr2_out;
    idex_t            idex_d;
    idex_t            idex_q;
    logic             idex_valid;
    logic             rf_we;
    lc3b_reg          rf_dest;
    lc3b_word         rf_wdata;
    retire_t          retire_next;

    control_rom control_rom_i (
        .opcode (lc3b_opcode'(instr[15:12])),
        .ir11   (instr[11]),
        .ir5    (instr[5]),
        .pc     (pc),
        .ctrl   (ctrl)
    );

    // stores read their data register from the dr field
    assign sr2_idx = ctrl.storemux_sel ? instr[11:9] : instr[2:0];
    assign dest = ctrl.dest_mux_sel ? lc3b_reg'(7) : instr[11:9];

    regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .sr1     (instr[8:6]),
        .sr2     (sr2_idx),
        .sr1_out (sr1_out),
        .sr2_out (sr2_out),
        .we      (rf_we),
        .dest    (rf_dest),
        .wdata   (rf_wdata)
    );

    assign idex_d = '{ctrl: ctrl, ir: instr, sr1_val: sr1_out, sr2_val: sr2_out, dest: dest};

    stage_reg #(.payload_t(idex_t)) idex_reg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (instr_valid),
        .in_data   (idex_d),
        .out_valid (idex_valid),
        .out_data  (idex_q)
    );

    exec_stage exec_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (idex_valid),
        .idex        (idex_q),
        .rf_we       (rf_we),
        .rf_dest     (rf_dest),
        .rf_wdata    (rf_wdata),
        .retire_next (retire_next)
    );

    stage_reg #(.payload_t(retire_t)) retire_reg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (idex_valid),
        .in_data   (retire_next),
        .out_valid (retire_valid),
        .out_data  (retire)
    );

endmodule : lc3b_decode_exec

// File: lc3b_decode_exec_assertions.sv
// lc3b execute stage assertions
// bubbles stay quiet, loads and stores never write the register file,
// branches, jumps and stores leave the condition codes alone

module lc3b_decode_exec_assertions
(
    input logic                             clk,
    input logic                             rst_n,
    input logic                             valid,
    input lc3b_ctrl_pkg::lc3b_control_word  ctrl,
    input logic                             rf_we,
    input logic [2:0]                       cc_q,
    input lc3b_ctrl_pkg::retire_t           retire_next
);

    import lc3b_types::*;

    // a bubble in execute has no side effect at all
    bubble_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !valid |-> !rf_we && !retire_next.mem_rd && !retire_next.mem_wr
                   && !retire_next.redirect)
        else $error("bubble in execute produced a write, memory request or redirect");

    // loads and trap leave the write to the memory stage
    load_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        valid && (ctrl.opcode inside {op_ldr, op_ldb, op_ldi, op_trap})
        |-> !rf_we && !retire_next.reg_we)
        else $error("load or trap wrote the register file in execute");

    store_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        valid && ctrl.dcacheW |-> !rf_we && !retire_next.mem_rd)
        else $error("store wrote a register or issued a read");

    // the edge that ends execute must not touch the codes
    cc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        valid && (ctrl.opcode inside {op_br, op_jmp, op_jsr, op_str, op_stb, op_trap})
        |=> $stable(cc_q))
        else $error("branch, jump, store or trap changed the condition codes");

endmodule : lc3b_decode_exec_assertions

bind exec_stage lc3b_decode_exec_assertions exec_assertions_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid       (valid),
    .ctrl        (ctrl),
    .rf_we       (rf_we),
    .cc_q        (cc_q),
    .retire_next (retire_next)
);

// File: tb_lc3b_decode_exec.sv
// lc3b decode and execute testbench
// directed and LCG driven instructions checked against an ISA model
// that tracks registers and condition codes

`include "lc3b_defines.svh"

module tb_lc3b_decode_exec;

    import lc3b_types::*;
    import lc3b_ctrl_pkg::*;

    logic     clk;
    logic     rst_n;
    logic     instr_valid;
    lc3b_word instr;
    lc3b_word pc;
    retire_t  retire;
    logic     retire_valid;

    lc3b_word    model_regs [`LC3B_NUM_REGS] = '{default: '0};
    logic [2:0]  model_cc = 3'b010;
    logic [31:0] lcg_state = 32'h1306_561e;
    lc3b_word    cur_pc = 16'h3000;
    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;

    // expectations with their test name and the edge that starts their decode cycle
    retire_t exp_q [$];
    string   name_q [$];
    int      edge_q [$];
    retire_t exp_rec;
    string   exp_name;
    int      exp_edge;

    lc3b_decode_exec lc3b_decode_exec_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [2:0] nzp_of(input lc3b_word v);
        if (v[15])
            return 3'b100;
        else if (v == '0)
            return 3'b010;
        return 3'b001;
    endfunction

    // ISA model, updates the model registers and CC in program order
    function automatic retire_t ref_model(input lc3b_word ins, input lc3b_word ipc);
        retire_t    r;
        lc3b_opcode op;
        lc3b_word   next_pc;
        lc3b_word   sr1_v;
        lc3b_word   sr2_v;
        lc3b_word   imm5;
        lc3b_word   off6;
        lc3b_word   result;
        lc3b_word   addr;
        logic       writes;
        logic       sets_cc;
        op = lc3b_opcode'(ins[15:12]);
        next_pc = ipc + 16'd2;
        sr1_v = model_regs[ins[8:6]];
        sr2_v = model_regs[ins[2:0]];
        imm5 = {{11{ins[4]}}, ins[4:0]};
        off6 = {{10{ins[5]}}, ins[5:0]};
        r = '0;
        r.dest = ins[11:9];
        result = '0;
        addr = '0;
        writes = 1'b0;
        sets_cc = 1'b0;
        case (op)
            op_add, op_and:
            begin
                result = (op == op_add) ? sr1_v + (ins[5] ? imm5 : sr2_v)
                                        : sr1_v & (ins[5] ? imm5 : sr2_v);
                writes = 1'b1;
                sets_cc = 1'b1;
            end
            op_not:
            begin
                result = ~sr1_v;
                writes = 1'b1;
                sets_cc = 1'b1;
            end
            op_shf:
            begin
                if (!ins[4])
                    result = sr1_v << ins[3:0];
                else if (ins[5])
                    result = lc3b_word'($signed(sr1_v) >>> ins[3:0]);
                else
                    result = sr1_v >> ins[3:0];
                writes = 1'b1;
                sets_cc = 1'b1;
            end
            op_lea:
            begin
                addr = next_pc + ({{7{ins[8]}}, ins[8:0]} << 1);
                result = addr;
                writes = 1'b1;
                sets_cc = 1'b1;
            end
            op_br:
            begin
                addr = next_pc + ({{7{ins[8]}}, ins[8:0]} << 1);
                r.redirect = |(ins[11:9] & model_cc);
            end
            op_jmp:
            begin
                addr = sr1_v;
                r.redirect = 1'b1;
            end
            op_jsr:
            begin
                // JSR is pc relative, JSRR goes through the base register
                addr = ins[11] ? next_pc + ({{5{ins[10]}}, ins[10:0]} << 1) : sr1_v;
                r.redirect = 1'b1;
                r.dest = 3'd7;
                result = next_pc;
                writes = 1'b1;
            end
            op_str, op_stb:
            begin
                addr = (op == op_str) ? sr1_v + (off6 << 1) : sr1_v + off6;
                r.mem_wr = 1'b1;
                r.mem_byte = (op == op_stb);
                r.mem_wdata = (op == op_str) ? model_regs[ins[11:9]]
                                             : {2{model_regs[ins[11:9]][7:0]}};
            end
            op_ldr, op_ldb:
            begin
                addr = (op == op_ldr) ? sr1_v + (off6 << 1) : sr1_v + off6;
                r.mem_rd = 1'b1;
                r.mem_byte = (op == op_ldb);
            end
            op_trap:
            begin
                addr = {7'b0, ins[7:0], 1'b0};
                r.mem_rd = 1'b1;
                r.dest = 3'd7;
            end
            default:
            begin
                r.redirect = 1'b0;
            end
        endcase
        if (sets_cc)
            model_cc = nzp_of(result);
        if (writes)
            model_regs[r.dest] = result;
        r.reg_we = writes;
        r.cc = model_cc;
        r.value = result;
        r.mem_addr = addr;
        r.target = addr;
        return r;
    endfunction

    function automatic lc3b_opcode pick_opcode(input logic [15:0] r);
        case (r % 16'd12)
            16'd0:   return op_add;
            16'd1:   return op_and;
            16'd2:   return op_not;
            16'd3:   return op_shf;
            16'd4:   return op_lea;
            16'd5:   return op_br;
            16'd6:   return op_jmp;
            16'd7:   return op_jsr;
            16'd8:   return op_str;
            16'd9:   return op_stb;
            16'd10:  return op_ldr;
            default: return op_trap;
        endcase
    endfunction

    function automatic lc3b_word random_instr(input lc3b_opcode op);
        logic [15:0] r;
        r = next_rand();
        case (op)
            op_not:  return {op, r[11:6], 6'h3f};
            op_jmp:  return {op, 3'b000, r[8:6], 6'h00};
            op_trap: return {op, 4'h0, r[7:0]};
            default: return {op, r[11:0]};
        endcase
    endfunction

    function automatic string group_of(input lc3b_opcode op);
        case (op)
            op_add, op_and, op_not: return "alu";
            op_shf:                 return "shf";
            op_lea, op_br, op_jmp, op_jsr: return "control";
            default:                return "memory";
        endcase
    endfunction

    task automatic issue_instr(input lc3b_word ins, input string name);
        instr_valid = 1'b1;
        instr = ins;
        pc = cur_pc;
        exp_q.push_back(ref_model(ins, cur_pc));
        name_q.push_back(name);
        edge_q.push_back(cyc);
        cur_pc = cur_pc + 16'd2;
        @(posedge clk);
        #2;
    endtask

    // garbage on instr, the pipe must ignore it
    task automatic insert_idle();
        instr_valid = 1'b0;
        instr = next_rand();
        pc = next_rand();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("Mismatch %s %s: expected %h actual %h", test, field, expected, actual);
        end
    endtask

    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            if (retire_valid)
            begin
                errors++;
                $display("retire_valid is high during reset");
            end
        end
        else if (retire_valid)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("retire at cycle %0d with no instruction in flight", cyc);
            end
            else
            begin
                exp_rec = exp_q.pop_front();
                exp_name = name_q.pop_front();
                exp_edge = edge_q.pop_front();
                check_value(exp_name, "latency", exp_edge + 2, cyc);
                check_value(exp_name, "reg_we", 32'(exp_rec.reg_we), 32'(retire.reg_we));
                check_value(exp_name, "dest", 32'(exp_rec.dest), 32'(retire.dest));
                check_value(exp_name, "cc", 32'(exp_rec.cc), 32'(retire.cc));
                check_value(exp_name, "mem_rd", 32'(exp_rec.mem_rd), 32'(retire.mem_rd));
                check_value(exp_name, "mem_wr", 32'(exp_rec.mem_wr), 32'(retire.mem_wr));
                check_value(exp_name, "mem_byte", 32'(exp_rec.mem_byte), 32'(retire.mem_byte));
                check_value(exp_name, "redirect", 32'(exp_rec.redirect), 32'(retire.redirect));
                if (exp_rec.reg_we)
                    check_value(exp_name, "value", 32'(exp_rec.value), 32'(retire.value));
                if (exp_rec.mem_rd || exp_rec.mem_wr)
                    check_value(exp_name, "mem_addr", 32'(exp_rec.mem_addr),
                                32'(retire.mem_addr));
                if (exp_rec.mem_wr)
                    check_value(exp_name, "mem_wdata", 32'(exp_rec.mem_wdata),
                                32'(retire.mem_wdata));
                if (exp_rec.redirect)
                    check_value(exp_name, "target", 32'(exp_rec.target), 32'(retire.target));
            end
        end
        else if (exp_q.size() != 0 && edge_q[0] + 2 <= cyc)
        begin
            errors++;
            $display("%s instruction issued after edge %0d never retired", name_q[0], edge_q[0]);
            exp_q.pop_front();
            name_q.pop_front();
            edge_q.pop_front();
        end
    end

    initial
    begin
        int         n;
        int         waited;
        lc3b_opcode op;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // CC comes out of reset as z, so BRz is taken
        issue_instr(16'h0404, "reset_cc");
        for (n = 0; n < `LC3B_NUM_REGS; n++)
            issue_instr({4'h1, 3'(n), 3'(n), 1'b1, 5'd0}, "reset_regs");

        // dependent chain with no gaps
        issue_instr({4'h1, 3'd1, 3'd0, 1'b1, 5'd7}, "fwd_chain");
        issue_instr({4'h1, 3'd1, 3'd1, 3'b000, 3'd1}, "fwd_chain");
        issue_instr({4'h1, 3'd1, 3'd1, 3'b000, 3'd1}, "fwd_chain");
        issue_instr({4'h5, 3'd3, 3'd1, 1'b1, 5'h1e}, "fwd_chain");
        issue_instr({4'h9, 3'd2, 3'd1, 6'h3f}, "alu_not");
        issue_instr({4'h0, 3'b001, 9'd8}, "br_not_taken");
        issue_instr({4'h0, 3'b100, 9'h1f0}, "br_taken");
        issue_instr({4'hd, 3'd5, 3'd2, 2'b00, 4'd3}, "shf_left");
        issue_instr({4'hd, 3'd5, 3'd2, 2'b01, 4'd3}, "shf_right");
        issue_instr({4'hd, 3'd5, 3'd2, 2'b11, 4'd3}, "shf_arith");
        issue_instr({4'he, 3'd6, 9'h1fb}, "lea");
        issue_instr({4'h4, 1'b1, 11'd16}, "jsr");
        issue_instr({4'h4, 1'b0, 2'b00, 3'd7, 6'd0}, "jsrr");
        issue_instr({4'hc, 3'b000, 3'd2, 6'd0}, "jmp");
        issue_instr({4'h7, 3'd1, 3'd2, 6'd3}, "str");
        issue_instr({4'h3, 3'd2, 3'd1, 6'h3f}, "stb");
        issue_instr({4'h6, 3'd3, 3'd1, 6'd2}, "ldr");
        insert_idle();
        issue_instr({4'hf, 4'h0, 8'h25}, "trap");

        for (n = 0; n < 400; n++)
        begin
            if (next_rand() % 16'd6 == 16'd0)
            begin
                insert_idle();
            end
            else
            begin
                op = pick_opcode(next_rand());
                issue_instr(random_instr(op), group_of(op));
            end
        end
        instr_valid = 1'b0;

        waited = 0;
        while (exp_q.size() != 0 && waited < 20)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            errors++;
            $display("timed out waiting for %0d outstanding retires", exp_q.size());
        end

        @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule : tb_lc3b_decode_exec

// File: lc3b_decode_exec.f
+incdir+.
lc3b_types.sv
lc3b_ctrl_pkg.sv
control_rom.sv
regfile.sv
stage_reg.sv
lc3b_alu.sv
exec_stage.sv
lc3b_decode_exec.sv
lc3b_decode_exec_assertions.sv
tb_lc3b_decode_exec.sv

// File: run.sh
#!/bin/sh
# build the lc3b decode/execute testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_lc3b_decode_exec \
    -f lc3b_decode_exec.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
